// ==== list.f ====
+incdir+test
verilog/scrmbl_pkg.sv
verilog/present_pkg.sv
verilog/scrmbl_ctrl.sv
verilog/scrmbl_key_state.sv
verilog/scrmbl_data_state.sv
verilog/scrmbl_top.sv
test/tb_scrmbl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the scrambler testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_scrmbl --Mdir build -o tb_scrmbl

./build/tb_scrmbl | tee sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi

// ==== test/tb_scrmbl_model.svh ====
`ifndef TB_SCRMBL_MODEL_SVH
`define TB_SCRMBL_MODEL_SVH

//////////////////////////////////////////////////
// present-128 reference
//////////////////////////////////////////////////

// standard present sbox, entry n is S(n)
function automatic logic [3:0] sbox_nibble(logic [3:0] x);
  logic [3:0] tbl [16];
  tbl = '{4'hc, 4'h5, 4'h6, 4'hb, 4'h9, 4'h0, 4'ha, 4'hd,
          4'h3, 4'he, 4'hf, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2};
  return tbl[x];
endfunction

function automatic logic [63:0] substitute_block(logic [63:0] d);
  logic [63:0] s;
  for (int n = 0; n < 16; n++) begin
    s[4*n +: 4] = sbox_nibble(d[4*n +: 4]);
  end
  return s;
endfunction

// bit i moves to 16*i mod 63, the top bit stays
function automatic logic [63:0] permute_bits(logic [63:0] d);
  logic [63:0] p;
  int          dst;
  for (int i = 0; i < 64; i++) begin
    dst    = (i == 63) ? 63 : (16 * i) % 63;
    p[dst] = d[i];
  end
  return p;
endfunction

// 128-bit schedule: rotate left 61, two sboxes on top, counter into bits 66..62
function automatic logic [127:0] next_round_key(logic [127:0] k, logic [4:0] rc);
  logic [127:0] r;
  r          = (k << 61) | (k >> 67);
  r[127:124] = sbox_nibble(r[127:124]);
  r[123:120] = sbox_nibble(r[123:120]);
  r[66:62]   = r[66:62] ^ rc;
  return r;
endfunction

function automatic logic [63:0] present_encrypt(logic [63:0] pt, logic [127:0] key);
  logic [63:0]  s;
  logic [127:0] k;
  s = pt;
  k = key;
  for (int r = 1; r <= NumRounds; r++) begin
    s = permute_bits(substitute_block(s ^ k[127:64]));
    k = next_round_key(k, 5'(r));
  end
  // final whitening with the last round key
  return s ^ k[127:64];
endfunction

//////////////////////////////////////////////////
// digest and random numbers
//////////////////////////////////////////////////

// chain value is the plaintext, message block is the key
function automatic logic [63:0] davies_meyer(logic [63:0] h, logic [127:0] m);
  return present_encrypt(h, m) ^ h;
endfunction

function automatic logic [31:0] xorshift32(logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// ==== test/tb_scrmbl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_scrmbl;

  localparam int NumRounds = 31;
  // generous bound on any handshake wait
  localparam int WaitLimit = 200;

  logic                    clk_i;
  logic                    rst_ni;
  scrmbl_pkg::scrmbl_req_t req_i;
  logic                    valid_i;
  logic                    ready_o;
  logic                    valid_o;
  scrmbl_pkg::block_t      data_o;

  int          errors;
  int          mon_errors;
  int          checks;
  bit          hung;
  bit          valid_seen;
  logic [31:0] rng_state;

  `include "tb_scrmbl_model.svh"

  scrmbl_top u_scrmbl_top (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .data_o  (data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic scrmbl_pkg::scrmbl_req_t make_req(scrmbl_pkg::cmd_e cmd,
      scrmbl_pkg::mode_e mode, scrmbl_pkg::sel_t sel, scrmbl_pkg::block_t data);
    scrmbl_pkg::scrmbl_req_t r;
    r.cmd  = cmd;
    r.mode = mode;
    r.sel  = sel;
    r.data = data;
    return r;
  endfunction

  task automatic compare_block(input string name, input scrmbl_pkg::block_t exp,
                               input scrmbl_pkg::block_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // waits for ready_o, then holds valid_i high for one cycle
  task automatic issue(input scrmbl_pkg::scrmbl_req_t req);
    int cycles;
    cycles = 0;
    if (!hung) begin
      @(negedge clk_i);
      while (!ready_o && cycles < WaitLimit) begin
        @(negedge clk_i);
        cycles++;
      end
      if (!ready_o) begin
        errors++;
        hung = 1'b1;
        $display("timeout while waiting for ready_o");
      end else begin
        @(posedge clk_i);
        req_i   <= req;
        valid_i <= 1'b1;
        @(posedge clk_i);
        valid_i <= 1'b0;
      end
    end
  endtask

  // load shadow and digest init finish at the accepting edge
  task automatic issue_single(input scrmbl_pkg::scrmbl_req_t req, input string name);
    issue(req);
    if (!hung) begin
      @(negedge clk_i);
      if (valid_o || !ready_o) begin
        errors++;
        $display("%s raised valid_o or dropped ready_o", name);
      end
    end
  endtask

  // round command; optionally pokes a second request in while busy
  task automatic run_round(input scrmbl_pkg::scrmbl_req_t req, input bit poke_busy,
                           input string name, output scrmbl_pkg::block_t result);
    int                      edges;
    scrmbl_pkg::scrmbl_req_t junk;
    result    = '0;
    edges     = 0;
    junk      = req;
    junk.sel  = ~req.sel;
    junk.data = {rand32(), rand32()};
    issue(req);
    if (!hung) begin
      @(negedge clk_i);
      while (!valid_o && edges < WaitLimit) begin
        if (ready_o) begin
          errors++;
          $display("ready_o was high while %s was running", name);
        end
        @(posedge clk_i);
        edges++;
        if (poke_busy && edges == 5) begin
          req_i   <= junk;
          valid_i <= 1'b1;
        end else begin
          valid_i <= 1'b0;
        end
        @(negedge clk_i);
      end
      if (!valid_o) begin
        errors++;
        hung = 1'b1;
        $display("timeout while waiting for valid_o after %s", name);
      end else begin
        result = data_o;
        checks++;
        if (edges != NumRounds) begin
          errors++;
          $display("[ERROR] %s latency: expected %0d, actual %0d", name, NumRounds, edges);
        end
        if (!ready_o) begin
          errors++;
          $display("ready_o was low in the result cycle of %s", name);
        end
      end
    end
  endtask

  // output gating and single-cycle pulse, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!valid_o && data_o !== '0) begin
        mon_errors++;
        $display("[ERROR] data_o gating: expected %h, actual %h", 64'h0, data_o);
      end
      if (valid_o && valid_seen) begin
        mon_errors++;
        $display("valid_o stayed high for more than one cycle");
      end
      valid_seen = valid_o;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    scrmbl_pkg::block_t blk;
    scrmbl_pkg::block_t shd;
    scrmbl_pkg::block_t res;
    scrmbl_pkg::block_t exp_a;
    scrmbl_pkg::block_t exp_b;
    scrmbl_pkg::block_t state;
    scrmbl_pkg::sel_t   sel;
    errors     = 0;
    mon_errors = 0;
    checks     = 0;
    hung       = 1'b0;
    valid_seen = 1'b0;
    rng_state  = 32'h9520fde3;
    rst_ni     = 1'b0;
    valid_i    = 1'b0;
    req_i      = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
      errors++;
      $display("after reset the DUT is not idle with ready_o high and valid_o low");
    end

    // known answer, zero block under the zero key
    run_round(make_req(scrmbl_pkg::CmdEncrypt, scrmbl_pkg::ModeStandard, 2'd0, '0),
              1'b0, "known vector", res);
    compare_block("known vector", 64'h96db702a2e6900af, res);

    // random blocks under random table keys, some with a busy poke
    for (int i = 0; i < 10; i++) begin
      sel = scrmbl_pkg::sel_t'(rand32());
      blk = {rand32(), rand32()};
      run_round(make_req(scrmbl_pkg::CmdEncrypt, scrmbl_pkg::ModeStandard, sel, blk),
                (i % 3) == 1, "encrypt", res);
      compare_block("encrypt", present_encrypt(blk, scrmbl_pkg::KeyTblDefault[sel]), res);
    end

    ////////////////////////////////////////////////
    // standard digest
    ////////////////////////////////////////////////
    sel   = scrmbl_pkg::sel_t'(rand32());
    state = scrmbl_pkg::IvTblDefault[sel];
    issue_single(make_req(scrmbl_pkg::CmdDigestInit, scrmbl_pkg::ModeStandard, sel, '0),
                 "digest init");
    for (int i = 0; i < 3; i++) begin
      shd = {rand32(), rand32()};
      blk = {rand32(), rand32()};
      issue_single(make_req(scrmbl_pkg::CmdLoadShadow, scrmbl_pkg::ModeStandard, '0, shd),
                   "load shadow");
      run_round(make_req(scrmbl_pkg::CmdDigest, scrmbl_pkg::ModeStandard, '0, blk),
                i == 1, "digest", res);
      state = davies_meyer(state, {blk, shd});
      compare_block("digest", state, res);
    end
    sel = scrmbl_pkg::sel_t'(rand32());
    run_round(make_req(scrmbl_pkg::CmdFinalize, scrmbl_pkg::ModeStandard, sel, '0),
              1'b0, "finalize", res);
    state = davies_meyer(state, scrmbl_pkg::ConstTblDefault[sel]);
    compare_block("finalize", state, res);

    ////////////////////////////////////////////////
    // chained digest with encrypts in between
    ////////////////////////////////////////////////
    sel   = scrmbl_pkg::sel_t'(rand32());
    state = scrmbl_pkg::IvTblDefault[sel];
    issue_single(make_req(scrmbl_pkg::CmdDigestInit, scrmbl_pkg::ModeChained, sel, '0),
                 "chained init");
    sel   = scrmbl_pkg::sel_t'(rand32());
    blk   = {rand32(), rand32()};
    exp_a = present_encrypt(blk, scrmbl_pkg::KeyTblDefault[sel]);
    run_round(make_req(scrmbl_pkg::CmdEncrypt, scrmbl_pkg::ModeStandard, sel, blk),
              1'b0, "encrypt a", res);
    compare_block("encrypt a", exp_a, res);
    // shadow takes result a, the data field is ignored here
    issue_single(make_req(scrmbl_pkg::CmdLoadShadow, scrmbl_pkg::ModeStandard, '0,
                 {rand32(), rand32()}), "shadow copy");
    sel   = scrmbl_pkg::sel_t'(rand32());
    blk   = {rand32(), rand32()};
    exp_b = present_encrypt(blk, scrmbl_pkg::KeyTblDefault[sel]);
    run_round(make_req(scrmbl_pkg::CmdEncrypt, scrmbl_pkg::ModeStandard, sel, blk),
              1'b1, "encrypt b", res);
    compare_block("encrypt b", exp_b, res);
    run_round(make_req(scrmbl_pkg::CmdDigest, scrmbl_pkg::ModeStandard, '0,
              {rand32(), rand32()}), 1'b0, "chained digest", res);
    state = davies_meyer(state, {exp_b, exp_a});
    compare_block("chained digest", state, res);
    sel = scrmbl_pkg::sel_t'(rand32());
    run_round(make_req(scrmbl_pkg::CmdFinalize, scrmbl_pkg::ModeStandard, sel, '0),
              1'b0, "chained finalize", res);
    state = davies_meyer(state, scrmbl_pkg::ConstTblDefault[sel]);
    compare_block("chained finalize", state, res);

    repeat (4) @(posedge clk_i);
    $display("summary: %0d checks, %0d errors", checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/present_pkg.sv ====
`default_nettype none

package present_pkg;

  //////////////////////////////////////////////////
  // present-128 round primitives
  //////////////////////////////////////////////////

  // 4-bit sbox, nibble n of the constant holds S(n)
  parameter logic [63:0] SBox4 = 64'h21748fe3_da09b65c;

  function automatic logic [3:0] sbox4(logic [3:0] x);
    return SBox4[4*x +: 4];
  endfunction

  // substitution layer over all 16 nibbles of a block
  function automatic scrmbl_pkg::block_t sbox_layer(scrmbl_pkg::block_t d);
    scrmbl_pkg::block_t s;
    for (int i = 0; i < scrmbl_pkg::BlockWidth / 4; i++) begin
      s[4*i +: 4] = sbox4(d[4*i +: 4]);
    end
    return s;
  endfunction

  // bit i goes to 16*i mod 63, bit 63 stays put
  function automatic scrmbl_pkg::block_t perm(scrmbl_pkg::block_t d);
    scrmbl_pkg::block_t p;
    for (int i = 0; i < scrmbl_pkg::BlockWidth; i++) begin
      p[(i % 4) * 16 + i / 4] = d[i];
    end
    return p;
  endfunction

  // 128-bit key schedule step
  //   rotate left by 61, two sboxes on the top byte,
  //   round counter folded into bits 66..62
  function automatic scrmbl_pkg::key_t key_update(
    scrmbl_pkg::key_t                     k,
    logic [scrmbl_pkg::RoundIdxWidth-1:0] idx
  );
    scrmbl_pkg::key_t r;
    r            = {k[66:0], k[127:67]};
    r[127:124]   = sbox4(r[127:124]);
    r[123:120]   = sbox4(r[123:120]);
    r[66:62]     = r[66:62] ^ idx;
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/scrmbl_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrmbl_ctrl #(
  parameter int num_rounds = 31
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire scrmbl_pkg::scrmbl_req_t req_i,
  input  wire                      valid_i,
  output logic                     ready_o,
  output logic                     valid_o,
  output scrmbl_pkg::scrmbl_ctrl_t ctrl_o
);

  localparam int CntWidth = $clog2(num_rounds + 1);
  localparam logic [CntWidth-1:0] LastCnt = CntWidth'(num_rounds - 1);

  // idle plus one round state per kind of run
  typedef enum logic [1:0] {
    IdleSt,
    EncSt,
    DigSt
  } state_e;

  state_e              state_d, state_q;
  logic [CntWidth-1:0] cnt_d, cnt_q;
  scrmbl_pkg::mode_e   mode_d, mode_q;
  logic                last_round;
  logic                valid_q;

  assign last_round = (state_q != IdleSt) && (cnt_q == LastCnt);
  assign valid_o    = valid_q;

  //////////////////////////////////////////////////
  // command decode and round sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    mode_d             = mode_q;
    cnt_d              = '0;
    ready_o            = 1'b0;
    ctrl_o             = '0;
    ctrl_o.last_round  = last_round;

    case (state_q)
      IdleSt: begin
        ready_o = 1'b1;
        if (valid_i) begin
          case (req_i.cmd)
            scrmbl_pkg::CmdEncrypt: begin
              state_d          = EncSt;
              ctrl_o.data_sel  = scrmbl_pkg::DataIn;
              ctrl_o.key_sel   = scrmbl_pkg::KeyTable;
              ctrl_o.data_en   = 1'b1;
              ctrl_o.key_en    = 1'b1;
            end
            scrmbl_pkg::CmdLoadShadow: begin
              // chained mode keeps the last result, standard mode takes data in
              if (mode_q == scrmbl_pkg::ModeChained) begin
                ctrl_o.shadow_copy = 1'b1;
              end else begin
                ctrl_o.shadow_load = 1'b1;
              end
            end
            scrmbl_pkg::CmdDigestInit: begin
              mode_d             = req_i.mode;
              ctrl_o.digest_init = 1'b1;
              ctrl_o.digest_en   = 1'b1;
            end
            scrmbl_pkg::CmdDigest: begin
              state_d          = DigSt;
              ctrl_o.data_sel  = scrmbl_pkg::DataDigest;
              ctrl_o.key_sel   = (mode_q == scrmbl_pkg::ModeChained) ?
                                 scrmbl_pkg::KeyChained : scrmbl_pkg::KeyStd;
              ctrl_o.data_en   = 1'b1;
              ctrl_o.key_en    = 1'b1;
            end
            scrmbl_pkg::CmdFinalize: begin
              // finalization ends the chain
              state_d          = DigSt;
              ctrl_o.data_sel  = scrmbl_pkg::DataDigest;
              ctrl_o.key_sel   = scrmbl_pkg::KeyConst;
              ctrl_o.data_en   = 1'b1;
              ctrl_o.key_en    = 1'b1;
              mode_d           = scrmbl_pkg::ModeStandard;
            end
            default: ;
          endcase
        end
      end
      EncSt, DigSt: begin
        ctrl_o.data_sel = scrmbl_pkg::DataRound;
        ctrl_o.key_sel  = scrmbl_pkg::KeyRound;
        ctrl_o.data_en  = 1'b1;
        ctrl_o.key_en   = 1'b1;
        cnt_d           = cnt_q + 1'b1;
        if (last_round) begin
          state_d = IdleSt;
          cnt_d   = '0;
          // digest runs apply the feed-forward and save the new chain value
          if (state_q == DigSt) begin
            ctrl_o.data_sel  = scrmbl_pkg::DataRoundFf;
            ctrl_o.digest_en = 1'b1;
          end
        end
      end
      default: state_d = IdleSt;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IdleSt;
      cnt_q   <= '0;
      mode_q  <= scrmbl_pkg::ModeStandard;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      mode_q  <= mode_d;
      valid_q <= last_round;
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // a round command keeps the port busy for exactly num_rounds cycles
  a_busy_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && ready_o && (state_d != IdleSt)) |=>
      (!ready_o && !valid_o) [*num_rounds] ##1 (ready_o && valid_o));

  // results come out as single-cycle pulses
  a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o);

endmodule

`default_nettype wire

// ==== verilog/scrmbl_data_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrmbl_data_state #(
  parameter int                  num_digest_sets = 4,
  parameter scrmbl_pkg::iv_tbl_t iv_tbl          = scrmbl_pkg::IvTblDefault
) (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire scrmbl_pkg::scrmbl_ctrl_t       ctrl_i,
  input  wire scrmbl_pkg::sel_t               sel_i,
  input  wire scrmbl_pkg::block_t             data_i,
  input  wire scrmbl_pkg::key_t               round_key_i,
  input  wire [scrmbl_pkg::RoundIdxWidth-1:0] round_idx_i,
  output scrmbl_pkg::block_t                  data_state_o,
  output scrmbl_pkg::block_t                  shadow_o,
  output scrmbl_pkg::block_t                  data_o
);

  localparam int KeyTop = scrmbl_pkg::KeyWidth - 1;
  localparam int BlkW   = scrmbl_pkg::BlockWidth;

  scrmbl_pkg::block_t data_d, data_q;
  scrmbl_pkg::block_t shadow_q;
  scrmbl_pkg::block_t digest_d, digest_q;
  scrmbl_pkg::block_t round_out, round_ff, iv;
  scrmbl_pkg::key_t   next_key;
  logic               valid_q;

  assign data_state_o = data_q;
  assign shadow_o     = shadow_q;

  //////////////////////////////////////////////////
  // one present round per cycle
  //////////////////////////////////////////////////

  // the advanced key only matters for the final whitening xor
  assign next_key = present_pkg::key_update(round_key_i, round_idx_i);

  always_comb begin
    round_out = present_pkg::perm(present_pkg::sbox_layer(
                  data_q ^ round_key_i[KeyTop -: BlkW]));
    if (ctrl_i.last_round) begin
      round_out = round_out ^ next_key[KeyTop -: BlkW];
    end
  end

  // davies-meyer feed-forward
  assign round_ff = round_out ^ digest_q;

  // sets beyond the populated ones read as zero
  assign iv = (sel_i < num_digest_sets) ? iv_tbl[sel_i] : '0;

  always_comb begin
    case (ctrl_i.data_sel)
      scrmbl_pkg::DataIn:      data_d = data_i;
      scrmbl_pkg::DataRound:   data_d = round_out;
      scrmbl_pkg::DataRoundFf: data_d = round_ff;
      scrmbl_pkg::DataDigest:  data_d = digest_q;
      default:                 data_d = data_q;
    endcase
  end

  assign digest_d = ctrl_i.digest_init ? iv : round_ff;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q   <= '0;
      shadow_q <= '0;
      digest_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= ctrl_i.last_round;
      if (ctrl_i.data_en) begin
        data_q <= data_d;
      end
      // copy wins, it only happens in chained mode
      if (ctrl_i.shadow_copy) begin
        shadow_q <= data_q;
      end else if (ctrl_i.shadow_load) begin
        shadow_q <= data_i;
      end
      if (ctrl_i.digest_en) begin
        digest_q <= digest_d;
      end
    end
  end

  // result is visible only in the cycle after the last round
  assign data_o = valid_q ? data_q : '0;

endmodule

`default_nettype wire

// ==== verilog/scrmbl_key_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrmbl_key_state #(
  parameter int                   num_keys        = 4,
  parameter int                   num_digest_sets = 4,
  parameter scrmbl_pkg::key_tbl_t key_tbl         = scrmbl_pkg::KeyTblDefault,
  parameter scrmbl_pkg::key_tbl_t const_tbl       = scrmbl_pkg::ConstTblDefault
) (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire scrmbl_pkg::scrmbl_ctrl_t        ctrl_i,
  input  wire scrmbl_pkg::sel_t                sel_i,
  input  wire scrmbl_pkg::block_t              data_i,
  input  wire scrmbl_pkg::block_t              data_state_i,
  input  wire scrmbl_pkg::block_t              shadow_i,
  output scrmbl_pkg::key_t                     round_key_o,
  output logic [scrmbl_pkg::RoundIdxWidth-1:0] round_idx_o
);

  scrmbl_pkg::key_t                     key_d, key_q;
  logic [scrmbl_pkg::RoundIdxWidth-1:0] idx_d, idx_q;

  assign round_key_o = key_q;
  assign round_idx_o = idx_q;

  //////////////////////////////////////////////////
  // key source select
  //////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.key_sel)
      scrmbl_pkg::KeyRound:   key_d = present_pkg::key_update(key_q, idx_q);
      scrmbl_pkg::KeyTable:   key_d = key_tbl[sel_i];
      scrmbl_pkg::KeyConst:   key_d = const_tbl[sel_i];
      // message block is the data input on top of the shadow
      scrmbl_pkg::KeyStd:     key_d = {data_i, shadow_i};
      // two previous results form the message block
      scrmbl_pkg::KeyChained: key_d = {data_state_i, shadow_i};
      default:                key_d = key_q;
    endcase
  end

  // round counter restarts at 1 on every fresh key
  assign idx_d = (ctrl_i.key_sel == scrmbl_pkg::KeyRound) ? idx_q + 1'b1 :
                 scrmbl_pkg::RoundIdxWidth'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
      idx_q <= '0;
    end else if (ctrl_i.key_en) begin
      key_q <= key_d;
      idx_q <= idx_d;
    end
  end

  // request select must address a populated table entry
  a_key_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_i.key_en && ctrl_i.key_sel == scrmbl_pkg::KeyTable) |-> (sel_i < num_keys));

  a_const_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_i.key_en && ctrl_i.key_sel == scrmbl_pkg::KeyConst) |-> (sel_i < num_digest_sets));

endmodule

`default_nettype wire

// ==== verilog/scrmbl_pkg.sv ====
`default_nettype none

package scrmbl_pkg;

  //////////////////////////////////////////////////
  // widths and basic types
  //////////////////////////////////////////////////

  parameter int BlockWidth    = 64;
  parameter int KeyWidth      = 128;
  parameter int SelWidth      = 2;
  parameter int RoundIdxWidth = 5;
  // every constant table is padded to the full select range
  parameter int NumTblEntries = 2 ** SelWidth;

  typedef logic [BlockWidth-1:0] block_t;
  typedef logic [KeyWidth-1:0]   key_t;
  typedef logic [SelWidth-1:0]   sel_t;

  typedef enum logic [2:0] {
    CmdEncrypt    = 3'd0,
    CmdLoadShadow = 3'd1,
    CmdDigestInit = 3'd2,
    CmdDigest     = 3'd3,
    CmdFinalize   = 3'd4
  } cmd_e;

  typedef enum logic {
    ModeStandard = 1'b0,
    ModeChained  = 1'b1
  } mode_e;

  typedef struct packed {
    cmd_e   cmd;
    mode_e  mode;
    sel_t   sel;
    block_t data;
  } scrmbl_req_t;

  //////////////////////////////////////////////////
  // datapath steering
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DataIn      = 2'd0,
    DataRound   = 2'd1,
    // round output xored with the digest state (davies-meyer)
    DataRoundFf = 2'd2,
    DataDigest  = 2'd3
  } data_sel_e;

  typedef enum logic [2:0] {
    KeyRound   = 3'd0,
    KeyTable   = 3'd1,
    KeyConst   = 3'd2,
    KeyStd     = 3'd3,
    KeyChained = 3'd4
  } key_sel_e;

  typedef struct packed {
    data_sel_e data_sel;
    key_sel_e  key_sel;
    logic      data_en;
    logic      key_en;
    logic      shadow_load;
    logic      shadow_copy;
    logic      digest_en;
    logic      digest_init;
    logic      last_round;
  } scrmbl_ctrl_t;

  //////////////////////////////////////////////////
  // default constant tables
  //////////////////////////////////////////////////

  typedef key_t   [NumTblEntries-1:0] key_tbl_t;
  typedef block_t [NumTblEntries-1:0] iv_tbl_t;

  // entry 3 first, entry 0 last
  parameter key_tbl_t KeyTblDefault = {
    128'h3ba71c52_e9d04f86_a13c7e25_d8b60f94,
    128'h7f0e9d2c_5b4a3918_2736a5c4_d3e2f100,
    128'h9c4e1a7b_30f58d62_e7b2c049_5da1863f,
    128'h00000000_00000000_00000000_00000000
  };

  parameter key_tbl_t ConstTblDefault = {
    128'hd6f1a803_4c97e25b_18e3b6d0_7a42c95f,
    128'h2b85e0f4_93c61d7a_6e0f5b28_c4d91a37,
    128'hf4a2c816_0b5d73e9_a8c3614f_27e90db5,
    128'h5e3790ab_c8421f6d_93b04ce7_1a65f28d
  };

  parameter iv_tbl_t IvTblDefault = {
    64'he17c2a94_b305d68f,
    64'h4d8b16f0_a9c273e5,
    64'h92f3c70d_1e6a845b,
    64'h0c5e9b31_f7d42a86
  };

endpackage

`default_nettype wire

// ==== verilog/scrmbl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrmbl_top #(
  parameter int                   num_rounds      = 31,
  parameter int                   num_keys        = 4,
  parameter int                   num_digest_sets = 4,
  parameter scrmbl_pkg::key_tbl_t key_tbl         = scrmbl_pkg::KeyTblDefault,
  parameter scrmbl_pkg::key_tbl_t const_tbl       = scrmbl_pkg::ConstTblDefault,
  parameter scrmbl_pkg::iv_tbl_t  iv_tbl          = scrmbl_pkg::IvTblDefault
) (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire scrmbl_pkg::scrmbl_req_t req_i,
  input  wire                          valid_i,
  output logic                         ready_o,
  output logic                         valid_o,
  output scrmbl_pkg::block_t           data_o
);

  scrmbl_pkg::scrmbl_ctrl_t             ctrl;
  scrmbl_pkg::key_t                     round_key;
  logic [scrmbl_pkg::RoundIdxWidth-1:0] round_idx;
  scrmbl_pkg::block_t                   data_state;
  scrmbl_pkg::block_t                   shadow;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  scrmbl_ctrl #(
    .num_rounds (num_rounds)
  ) u_scrmbl_ctrl (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .ctrl_o  (ctrl)
  );

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  scrmbl_key_state #(
    .num_keys        (num_keys),
    .num_digest_sets (num_digest_sets),
    .key_tbl         (key_tbl),
    .const_tbl       (const_tbl)
  ) u_scrmbl_key_state (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_i       (ctrl),
    .sel_i        (req_i.sel),
    .data_i       (req_i.data),
    .data_state_i (data_state),
    .shadow_i     (shadow),
    .round_key_o  (round_key),
    .round_idx_o  (round_idx)
  );

  scrmbl_data_state #(
    .num_digest_sets (num_digest_sets),
    .iv_tbl          (iv_tbl)
  ) u_scrmbl_data_state (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_i       (ctrl),
    .sel_i        (req_i.sel),
    .data_i       (req_i.data),
    .round_key_i  (round_key),
    .round_idx_i  (round_idx),
    .data_state_o (data_state),
    .shadow_o     (shadow),
    .data_o       (data_o)
  );

endmodule

`default_nettype wire
